/* hw/fp_pkg.sv */
`default_nettype none

package fp_pkg;

  // ieee-754 single precision fields
  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [22:0] frac;
  } fp32_fields_t;

  // same word seen as bus data or as decoded fields
  typedef union packed {
    logic [31:0]  bits;
    fp32_fields_t f;
  } fp32_t;

  // cycles from issue to res_valid
  localparam int FP_MUL_LATENCY = 6;

  // byte offsets on the axi4-lite bus
  localparam logic [3:0] REG_A      = 4'h0;
  localparam logic [3:0] REG_B      = 4'h4;
  localparam logic [3:0] REG_LAUNCH = 4'h8;
  localparam logic [3:0] REG_RESULT = 4'h8;
  localparam logic [3:0] REG_STATUS = 4'hC;

  // status word layout
  localparam int STATUS_EMPTY_BIT = 0;
  localparam int STATUS_FULL_BIT  = 1;
  localparam int STATUS_COUNT_LSB = 8;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* hw/fp32_round.sv */
`default_nettype none

module fp32_round (
  input  logic        clk_in,
  input  logic [8:0]  norm_exp,
  input  logic [47:0] norm_frac,
  output logic [8:0]  round_exp,
  output logic [22:0] round_frac
);

  logic [22:0] kept;
  logic        guard;
  logic        round_bit;
  logic        sticky;
  logic        round_up;
  logic [23:0] frac_sum;

  // leading one sits at bit 47, so the fraction is the next 23 bits
  assign kept      = norm_frac[46:24];
  assign guard     = norm_frac[23];
  assign round_bit = norm_frac[22];
  assign sticky    = |norm_frac[21:0];

  // nearest even: ties go up only when the kept lsb is odd
  assign round_up = guard && (round_bit || sticky || kept[0]);

  assign frac_sum = {1'b0, kept} + {23'd0, round_up};

  always_ff @(posedge clk_in) begin
    if (frac_sum[23]) begin
      // mantissa overflowed to 10.000, bump the exponent
      round_exp  <= norm_exp + 9'd1;
      round_frac <= 23'd0;
    end else begin
      round_exp  <= norm_exp;
      round_frac <= frac_sum[22:0];
    end
  end

endmodule

`default_nettype wire

/* hw/fp32_mul.sv */
`default_nettype none

module fp32_mul (
  input  logic          clk_in,
  input  logic          rst_n,
  input  logic          issue,
  input  fp_pkg::fp32_t op_a,
  input  fp_pkg::fp32_t op_b,
  output logic          res_valid,
  output fp_pkg::fp32_t res
);

  import fp_pkg::*;

  // stage 1 captured operands
  logic        a_sign;
  logic        b_sign;
  logic [8:0]  a_exp;
  logic [8:0]  b_exp;
  logic [23:0] a_sig;
  logic [23:0] b_sig;

  // stage 2 to 4 datapath
  logic [8:0]  exp_sum;
  logic [47:0] sig_prod;
  logic [8:0]  base_exp;
  logic [47:0] base_sig;
  logic [8:0]  norm_exp;
  logic [47:0] norm_sig;

  // stage 5 rounder output
  logic [8:0]  round_exp;
  logic [22:0] round_frac;

  // sign and special flags ride beside stages 2 to 5
  logic        in_zero;
  logic        in_inf;
  logic [3:0][2:0] side_sr;
  logic        out_sign;
  logic        out_zero;
  logic        out_inf;

  logic [FP_MUL_LATENCY-1:0] valid_sr;

  // stage 1
  always_ff @(posedge clk_in) begin
    a_sign <= op_a.f.sign;
    b_sign <= op_b.f.sign;
    a_exp  <= {1'b0, op_a.f.exp};
    b_exp  <= {1'b0, op_b.f.exp};
    // hidden one only for a nonzero exponent
    a_sig  <= {op_a.f.exp != 8'd0, op_a.f.frac};
    b_sig  <= {op_b.f.exp != 8'd0, op_b.f.frac};
  end

  assign in_zero = (a_exp == 9'd0) || (b_exp == 9'd0);
  assign in_inf  = (a_exp == 9'd255) || (b_exp == 9'd255);

  always_ff @(posedge clk_in) begin
    side_sr <= {side_sr[2:0], {a_sign ^ b_sign, in_zero, in_inf}};
  end

  assign {out_sign, out_zero, out_inf} = side_sr[3];

  // stage 2
  always_ff @(posedge clk_in) begin
    exp_sum  <= a_exp + b_exp;
    sig_prod <= a_sig * b_sig;
  end

  // stage 3 removes the bias, negative results wrap above 383
  always_ff @(posedge clk_in) begin
    base_exp <= exp_sum - 9'd127;
    base_sig <= sig_prod;
  end

  // stage 4
  always_ff @(posedge clk_in) begin
    if (base_sig[47]) begin
      // product is 1x.xxx
      norm_exp <= base_exp + 9'd1;
      norm_sig <= base_sig;
    end else begin
      norm_exp <= base_exp;
      norm_sig <= {base_sig[46:0], 1'b0};
    end
  end

  // stage 5
  fp32_round u_round (
    .clk_in     (clk_in),
    .norm_exp   (norm_exp),
    .norm_frac  (norm_sig),
    .round_exp  (round_exp),
    .round_frac (round_frac)
  );

  // stage 6 clamp to zero or infinity
  always_ff @(posedge clk_in) begin
    res.f.sign <= out_sign;
    if (out_zero) begin
      res.f.exp  <= 8'd0;
      res.f.frac <= 23'd0;
    end else if (out_inf) begin
      res.f.exp  <= 8'hFF;
      res.f.frac <= 23'd0;
    end else if (round_exp >= 9'd384 || round_exp == 9'd0) begin
      // underflow, denormals flush to zero
      res.f.exp  <= 8'd0;
      res.f.frac <= 23'd0;
    end else if (round_exp >= 9'd255) begin
      res.f.exp  <= 8'hFF;
      res.f.frac <= 23'd0;
    end else begin
      res.f.exp  <= round_exp[7:0];
      res.f.frac <= round_frac;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[FP_MUL_LATENCY-2:0], issue};
    end
  end

  assign res_valid = valid_sr[FP_MUL_LATENCY-1];

endmodule

`default_nettype wire

/* hw/fp_axil_write.sv */
`default_nettype none

module fp_axil_write (
  input  logic          clk_in,
  input  logic          rst_n,
  input  logic          awvalid,
  input  logic [3:0]    awaddr,
  output logic          awready,
  input  logic          wvalid,
  input  logic [31:0]   wdata,
  output logic          wready,
  output logic          bvalid,
  input  logic          bready,
  output logic [1:0]    bresp,
  input  logic          credit_ok,
  output logic          issue,
  output fp_pkg::fp32_t op_a,
  output fp_pkg::fp32_t op_b
);

  import fp_pkg::*;

  logic accept;
  logic wr_fire;

  // aw and w are taken together in one cycle
  assign awready = accept;
  assign wready  = accept;
  assign wr_fire = awvalid && wvalid && accept;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      accept <= 1'b0;
    end else begin
      // single-cycle ready pulse, blocked while a response waits
      accept <= awvalid && wvalid && !accept && !bvalid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      bresp  <= AXI_RESP_OKAY;
      issue  <= 1'b0;
    end else begin
      issue <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (awaddr)
          REG_A, REG_B: begin
            bresp <= AXI_RESP_OKAY;
          end
          REG_LAUNCH: begin
            // no credit means the result could not be queued
            if (credit_ok) begin
              issue <= 1'b1;
              bresp <= AXI_RESP_OKAY;
            end else begin
              bresp <= AXI_RESP_SLVERR;
            end
          end
          default: begin
            bresp <= AXI_RESP_SLVERR;
          end
        endcase
      end
    end
  end

  // operand registers
  always_ff @(posedge clk_in) begin
    if (wr_fire && awaddr == REG_A) begin
      op_a.bits <= wdata;
    end
    if (wr_fire && awaddr == REG_B) begin
      op_b.bits <= wdata;
    end
  end

endmodule

`default_nettype wire

/* hw/fp_result_queue.sv */
`default_nettype none

module fp_result_queue #(
  parameter int RESULT_DEPTH = 4
) (
  input  logic          clk_in,
  input  logic          rst_n,
  input  logic          issue,
  input  logic          res_valid,
  input  fp_pkg::fp32_t res,
  input  fp_pkg::fp32_t op_a,
  input  fp_pkg::fp32_t op_b,
  output logic          credit_ok,
  input  logic          arvalid,
  input  logic [3:0]    araddr,
  output logic          arready,
  output logic          rvalid,
  input  logic          rready,
  output logic [31:0]   rdata,
  output logic [1:0]    rresp
);

  import fp_pkg::*;

  localparam int PTR_W = $clog2(RESULT_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  fp32_t fifo_mem [RESULT_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] inflight;
  logic             empty;
  logic             full;
  logic             push;
  logic             pop;
  logic             rd_fire;
  logic [31:0]      status;

  assign empty = count == '0;
  assign full  = count == CNT_W'(RESULT_DEPTH);

  // stored plus in flight must leave room, so a result is never dropped
  assign credit_ok = ({1'b0, count} + {1'b0, inflight}) < (CNT_W + 1)'(RESULT_DEPTH);

  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;
  assign push    = res_valid;
  assign pop     = rd_fire && araddr == REG_RESULT && !empty;

  always_comb begin
    status = '0;
    status[STATUS_EMPTY_BIT] = empty;
    status[STATUS_FULL_BIT]  = full;
    status[STATUS_COUNT_LSB +: 8] = 8'(count);
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      inflight <= '0;
      count    <= '0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
    end else begin
      case ({issue, res_valid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // depth is a power of two so pointers wrap on their own
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) begin
      fifo_mem[wr_ptr] <= res;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // read data is held until rready since it only loads on acceptance
  always_ff @(posedge clk_in) begin
    if (rd_fire) begin
      rdata <= '0;
      rresp <= AXI_RESP_OKAY;
      case (araddr)
        REG_A:      rdata <= op_a.bits;
        REG_B:      rdata <= op_b.bits;
        REG_STATUS: rdata <= status;
        REG_RESULT: begin
          if (empty) begin
            rresp <= AXI_RESP_SLVERR;
          end else begin
            rdata <= fifo_mem[rd_ptr].bits;
          end
        end
        default:    rresp <= AXI_RESP_SLVERR;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/fp_mul_top.sv */
`default_nettype none

module fp_mul_top #(
  parameter int RESULT_DEPTH = 4
) (
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        awvalid,
  output logic        awready,
  input  logic [3:0]  awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [3:0]  araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp
);

  import fp_pkg::*;

  logic  issue;
  logic  credit_ok;
  logic  res_valid;
  fp32_t op_a;
  fp32_t op_b;
  fp32_t res;

  // only full-word writes are supported, wstrb is not decoded
  fp_axil_write u_write (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awready   (awready),
    .wvalid    (wvalid),
    .wdata     (wdata),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .credit_ok (credit_ok),
    .issue     (issue),
    .op_a      (op_a),
    .op_b      (op_b)
  );

  fp32_mul u_mul (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .issue     (issue),
    .op_a      (op_a),
    .op_b      (op_b),
    .res_valid (res_valid),
    .res       (res)
  );

  fp_result_queue #(
    .RESULT_DEPTH (RESULT_DEPTH)
  ) u_queue (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .issue     (issue),
    .res_valid (res_valid),
    .res       (res),
    .op_a      (op_a),
    .op_b      (op_b),
    .credit_ok (credit_ok),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arready   (arready),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp)
  );

endmodule

`default_nettype wire

/* tests/fp_mul_assert.sv */
`default_nettype none

module fp_mul_assert #(
  parameter int DEPTH = 4,
  parameter int CNT_W = 3,
  parameter bit CHECK_FILL = 1'b1
) (
  input logic             clk_in,
  input logic             rst_n,
  input logic             valid,
  input logic             ready,
  input logic [31:0]      data,
  input logic             issue,
  input logic             credit_ok,
  input logic [CNT_W-1:0] fill
);

  // a response waits for its handshake
  valid_held: assert property (@(posedge clk_in) disable iff (!rst_n)
    valid && !ready |=> valid)
    else $error("valid dropped before ready");

  data_stable: assert property (@(posedge clk_in) disable iff (!rst_n)
    valid && !ready |=> $stable(data))
    else $error("data changed while waiting for ready");

  // the launch was decided one cycle earlier
  issue_credit: assert property (@(posedge clk_in) disable iff (!rst_n)
    issue |-> $past(credit_ok))
    else $error("issue without credit");

  if (CHECK_FILL) begin : g_fill
    fill_limit: assert property (@(posedge clk_in) disable iff (!rst_n)
      fill <= CNT_W'(DEPTH))
      else $error("fifo count above depth");
  end

endmodule

bind fp_result_queue fp_mul_assert #(
  .DEPTH (RESULT_DEPTH),
  .CNT_W (CNT_W)
) u_queue_assert (
  .clk_in    (clk_in),
  .rst_n     (rst_n),
  .valid     (rvalid),
  .ready     (rready),
  .data      (rdata),
  .issue     (issue),
  .credit_ok (credit_ok),
  .fill      (count)
);

// write response channel and launch credit
bind fp_axil_write fp_mul_assert #(
  .CHECK_FILL (1'b0)
) u_write_assert (
  .clk_in    (clk_in),
  .rst_n     (rst_n),
  .valid     (bvalid),
  .ready     (bready),
  .data      ({30'd0, bresp}),
  .issue     (issue),
  .credit_ok (credit_ok),
  .fill      (3'd0)
);

`default_nettype wire

/* tests/fp_mul_tb.sv */
`default_nettype none

module fp_mul_tb;

  import fp_pkg::*;

  localparam int DEPTH = 4;
  // all tests together run in about 2500 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic        clk_in;
  logic        rst_n;
  logic        awvalid;
  logic        awready;
  logic [3:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [3:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  int          pass_count;
  int          fail_count;
  int          cycles;
  logic [31:0] rng_state;

  fp_mul_top #(
    .RESULT_DEPTH (DEPTH)
  ) u_fp_mul_top (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      cycles++;
    end
    $display("timeout after %0d cycles, a handshake or result never arrived", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // random sign and fraction with the exponent kept in 64..190
  function automatic fp32_t normal_operand(input logic [31:0] raw, input logic [31:0] pick);
    fp32_t v;
    v.bits  = raw;
    v.f.exp = 8'(32'd64 + pick % 32'd127);
    return v;
  endfunction

  function automatic logic [31:0] status_word(input logic empty, input logic full,
                                              input logic [7:0] count);
    return {16'd0, count, 6'd0, full, empty};
  endfunction

  // reference product where a zero operand wins over infinity
  function automatic fp32_t ref_mul(input fp32_t a, input fp32_t b);
    fp32_t       r;
    logic [47:0] prod;
    logic [23:0] mant;
    logic        guard;
    logic        below;
    int          e;
    r.bits   = '0;
    r.f.sign = a.f.sign ^ b.f.sign;
    if (a.f.exp == 8'd0 || b.f.exp == 8'd0) begin
      return r;
    end
    if (a.f.exp == 8'hFF || b.f.exp == 8'hFF) begin
      r.f.exp = 8'hFF;
      return r;
    end
    prod = 48'({1'b1, a.f.frac}) * 48'({1'b1, b.f.frac});
    e = int'(a.f.exp) + int'(b.f.exp) - 127;
    if (prod[47]) begin
      e = e + 1;
    end else begin
      prod = prod << 1;
    end
    mant  = {1'b0, prod[46:24]};
    guard = prod[23];
    below = |prod[22:0];
    // ties go to the even fraction
    if (guard && (below || mant[0])) begin
      mant = mant + 24'd1;
    end
    if (mant[23]) begin
      e = e + 1;
    end
    if (e <= 0) begin
      return r;
    end
    if (e >= 255) begin
      r.f.exp = 8'hFF;
      return r;
    end
    r.f.exp  = 8'(e);
    r.f.frac = mant[22:0];
    return r;
  endfunction

  task automatic check_fp(input string name, input fp32_t want, input fp32_t got);
    if (got.bits === want.bits) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("MISMATCH %s expected %h got %h", name, want.bits, got.bits);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] want, input logic [1:0] got);
    if (got === want) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("MISMATCH %s expected %h got %h", name, want, got);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] want, input logic [31:0] got);
    if (got === want) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("MISMATCH %s expected %h got %h", name, want, got);
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (fail_count == fails_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, fail_count - fails_before);
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    do @(posedge clk_in); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge clk_in); while (!bvalid);
    resp = bresp;
    // response waits one cycle before it is accepted
    bready <= 1'b1;
    @(posedge clk_in);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    arvalid <= 1'b1;
    araddr  <= addr;
    do @(posedge clk_in); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk_in); while (!rvalid);
    data = rdata;
    resp = rresp;
    // read data waits one cycle before it is accepted
    rready <= 1'b1;
    @(posedge clk_in);
    rready <= 1'b0;
  endtask

  task automatic poll_status(input int bit_index, input logic want);
    logic [31:0] data;
    logic [1:0]  resp;
    do begin
      axil_read(REG_STATUS, data, resp);
    end while (data[bit_index] !== want);
  endtask

  // one full launch, wait for the queue, then pop and compare
  task automatic run_product(input logic [31:0] a_bits, input logic [31:0] b_bits);
    fp32_t       a;
    fp32_t       b;
    fp32_t       got;
    logic [31:0] data;
    logic [1:0]  resp;
    a.bits = a_bits;
    b.bits = b_bits;
    axil_write(REG_A, a.bits, resp);
    check_resp("bresp", AXI_RESP_OKAY, resp);
    axil_write(REG_B, b.bits, resp);
    check_resp("bresp", AXI_RESP_OKAY, resp);
    axil_write(REG_LAUNCH, 32'd0, resp);
    check_resp("bresp", AXI_RESP_OKAY, resp);
    poll_status(STATUS_EMPTY_BIT, 1'b0);
    axil_read(REG_RESULT, data, resp);
    check_resp("rresp", AXI_RESP_OKAY, resp);
    got.bits = data;
    check_fp("result", ref_mul(a, b), got);
  endtask

  task automatic register_access();
    int          fails_before;
    logic [31:0] data;
    logic [1:0]  resp;
    fails_before = fail_count;
    axil_read(REG_STATUS, data, resp);
    check_resp("rresp", AXI_RESP_OKAY, resp);
    check_word("status", status_word(1'b1, 1'b0, 8'd0), data);
    axil_write(REG_A, 32'h3FC0_0000, resp);
    check_resp("bresp", AXI_RESP_OKAY, resp);
    axil_write(REG_B, 32'hC123_4567, resp);
    check_resp("bresp", AXI_RESP_OKAY, resp);
    axil_read(REG_A, data, resp);
    check_resp("rresp", AXI_RESP_OKAY, resp);
    check_word("op_a", 32'h3FC0_0000, data);
    axil_read(REG_B, data, resp);
    check_resp("rresp", AXI_RESP_OKAY, resp);
    check_word("op_b", 32'hC123_4567, data);
    // status is read only
    axil_write(REG_STATUS, 32'hDEAD_BEEF, resp);
    check_resp("bresp", AXI_RESP_SLVERR, resp);
    axil_read(REG_RESULT, data, resp);
    check_resp("rresp", AXI_RESP_SLVERR, resp);
    check_word("rdata", 32'd0, data);
    report_test("register_access", fails_before);
  endtask

  task automatic exact_products();
    int fails_before;
    fails_before = fail_count;
    // 1.5 * 2.0
    run_product(32'h3FC0_0000, 32'h4000_0000);
    // -3.0 * 0.5
    run_product(32'hC040_0000, 32'h3F00_0000);
    run_product(32'h4040_0000, 32'h4040_0000);
    report_test("exact_products", fails_before);
  endtask

  task automatic rounding_cases();
    int          fails_before;
    fp32_t       a;
    fp32_t       b;
    logic [31:0] raw;
    fails_before = fail_count;
    // exact half with odd lsb goes up
    run_product(32'h3F80_0001, 32'h3FC0_0000);
    // exact half with even lsb stays
    run_product(32'h3F80_0800, 32'h3F80_0800);
    run_product(32'h3F80_0800, 32'h3F80_0801);
    // significands multiply to 2^47 - 1 so rounding carries into the exponent
    run_product(32'h3FA1_E58F, 32'h3FCA_6691);
    for (int i = 0; i < 64; i++) begin
      rng_state = xorshift32(rng_state);
      raw = rng_state;
      rng_state = xorshift32(rng_state);
      a = normal_operand(raw, rng_state);
      rng_state = xorshift32(rng_state);
      raw = rng_state;
      rng_state = xorshift32(rng_state);
      b = normal_operand(raw, rng_state);
      run_product(a.bits, b.bits);
    end
    report_test("rounding_cases", fails_before);
  endtask

  task automatic special_values();
    int fails_before;
    fails_before = fail_count;
    run_product(32'h0000_0000, 32'h4040_0000);
    run_product(32'h8000_0000, 32'h4040_0000);
    run_product(32'h7F80_0000, 32'hC000_0000);
    // a nan pattern still gives plain infinity
    run_product(32'h7FC0_0000, 32'h3F80_0000);
    run_product(32'h0000_0000, 32'h7F80_0000);
    // overflow and underflow
    run_product(32'h7F00_0000, 32'h7F00_0000);
    run_product(32'h0080_0000, 32'h0080_0000);
    // denormal input flushed
    run_product(32'h0040_0000, 32'h4000_0000);
    report_test("special_values", fails_before);
  endtask

  task automatic backpressure_order();
    int          fails_before;
    fp32_t       a;
    fp32_t       b;
    fp32_t       got;
    fp32_t       launched[$];
    logic [31:0] data;
    logic [1:0]  resp;
    fails_before = fail_count;
    b.bits = 32'hC040_0000;
    axil_write(REG_B, b.bits, resp);
    check_resp("bresp", AXI_RESP_OKAY, resp);
    for (int i = 0; i < DEPTH + 2; i++) begin
      a.bits = 32'h3F80_0000 | (32'(i) << 19);
      axil_write(REG_A, a.bits, resp);
      check_resp("bresp", AXI_RESP_OKAY, resp);
      axil_write(REG_LAUNCH, 32'd0, resp);
      // only DEPTH slots exist while nothing is read
      check_resp("bresp", (i < DEPTH) ? AXI_RESP_OKAY : AXI_RESP_SLVERR, resp);
      if (i < DEPTH) begin
        launched.push_back(ref_mul(a, b));
      end
    end
    poll_status(STATUS_FULL_BIT, 1'b1);
    axil_read(REG_STATUS, data, resp);
    check_word("status", status_word(1'b0, 1'b1, 8'(DEPTH)), data);
    while (launched.size() > 0) begin
      axil_read(REG_RESULT, data, resp);
      check_resp("rresp", AXI_RESP_OKAY, resp);
      got.bits = data;
      check_fp("result", launched.pop_front(), got);
    end
    axil_read(REG_STATUS, data, resp);
    check_word("status", status_word(1'b1, 1'b0, 8'd0), data);
    report_test("backpressure_order", fails_before);
  endtask

  initial begin
    rst_n      = 1'b0;
    awvalid    = 1'b0;
    awaddr     = 4'h0;
    wvalid     = 1'b0;
    wdata      = 32'd0;
    wstrb      = 4'h0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = 4'h0;
    rready     = 1'b0;
    pass_count = 0;
    fail_count = 0;
    rng_state  = 32'h1f5d;
    repeat (5) @(posedge clk_in);
    rst_n <= 1'b1;
    @(posedge clk_in);
    register_access();
    exact_products();
    rounding_cases();
    special_values();
    backpressure_order();
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hw/fp_pkg.sv
hw/fp32_round.sv
hw/fp32_mul.sv
hw/fp_axil_write.sv
hw/fp_result_queue.sv
hw/fp_mul_top.sv
tests/fp_mul_assert.sv
tests/fp_mul_tb.sv

/* Makefile */
TOP := fp_mul_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf obj_dir
